/* sim.f */
design/mem_pkg.sv
design/xfer_if.sv
design/xfer_fsm.sv
design/byte_counter.sv
design/ram_port.sv
design/line_collect.sv
design/mem_ctrl.sv
bench/mem_ctrl_chk.sv
bench/mem_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs the memory controller testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module mem_ctrl_tb \
    -Mdir obj_dir -o mem_ctrl_sim; then
  echo "build error"
  exit 1
fi

if ! ./obj_dir/mem_ctrl_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi

exit 0

/* bench/mem_ctrl_tb.sv */
`timescale 1ns/1ns

module mem_ctrl_tb;

  localparam int RAM_BYTES = 131072;
  localparam int N_TESTS = 6;
  localparam int N_TRANS = 40;
  localparam int TIMEOUT = N_TESTS * N_TRANS * (mem_pkg::LINE_BYTES + 2) * 4;

  logic clk_in;
  logic rst_in;
  logic rdy_in;
  mem_pkg::byte_t mem_din;
  mem_pkg::byte_t mem_dout;
  mem_pkg::addr_t mem_a;
  logic mem_wr;
  logic if_valid;
  mem_pkg::addr_t if_addr;
  logic if_ready;
  mem_pkg::line_t if_line;
  logic d_valid;
  logic d_wr;
  mem_pkg::addr_t d_addr;
  mem_pkg::line_t d_wline;
  logic d_ready;
  mem_pkg::line_t d_rline;
  logic io_valid;
  logic io_wr;
  mem_pkg::byte_t io_wdata;
  logic io_ready;
  mem_pkg::byte_t io_rdata;
  logic is_io_buffer_full;

  mem_pkg::byte_t ram [0:RAM_BYTES-1];
  mem_pkg::byte_t io_in_byte;
  mem_pkg::byte_t io_out_q[$];

  integer seed;
  integer knob_seed;
  int errors;
  int checks;
  int cycles;
  int test_errs;
  logic rand_rdy;
  logic rand_full;
  logic uart_busy;

  mem_ctrl DUT (.*);

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("run stopped: no finish after %0d cycles", TIMEOUT);
      $display("Testbench failed");
      $finish;
    end
  end

  // pause knob, and a one-byte uart buffer that drains at random
  always @(posedge clk_in) begin
    rdy_in <= rand_rdy ? (({$random(knob_seed)} % 4) != 0) : 1'b1;
    if (!rand_full) begin
      uart_busy = 1'b0;
    end else if (mem_wr && mem_a == mem_pkg::IO_BASE) begin
      uart_busy = 1'b1;
    end else if (({$random(knob_seed)} % 4) == 0) begin
      uart_busy = 1'b0;
    end
    is_io_buffer_full <= uart_busy;
  end

  // RAM answers one cycle late, the uart sits at IO_BASE
  always @(posedge clk_in) begin
    if (mem_a == mem_pkg::IO_BASE) begin
      mem_din <= io_in_byte;
    end else begin
      mem_din <= ram[mem_a[16:0]];
    end
    if (mem_wr) begin
      if (!rdy_in) begin
        $display("write landed at %h while rdy_in was low", mem_a);
        errors++;
      end
      if (mem_a == mem_pkg::IO_BASE) begin
        io_out_q.push_back(mem_dout);
      end else begin
        ram[mem_a[16:0]] <= mem_dout;
      end
    end
  end

  function automatic mem_pkg::line_t model_line(input mem_pkg::addr_t addr);
    mem_pkg::line_t l;
    int i;
    for (i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      l[i] = ram[addr[16:0] + i];
    end
    return l;
  endfunction

  function automatic mem_pkg::line_t rand_line();
    mem_pkg::line_t l;
    int i;
    for (i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      l[i] = mem_pkg::byte_t'($random(seed));
    end
    return l;
  endfunction

  function automatic mem_pkg::addr_t rand_addr();
    return {$random(seed)} % (RAM_BYTES - mem_pkg::LINE_BYTES);
  endfunction

  function automatic mem_pkg::xfer_kind_t rand_kind();
    case ({$random(seed)} % 5)
      0: return mem_pkg::IF_READ;
      1: return mem_pkg::D_READ;
      2: return mem_pkg::D_WRITE;
      3: return mem_pkg::IO_READ;
      default: return mem_pkg::IO_WRITE;
    endcase
  endfunction

  task automatic set_knobs(input logic rdy_knob, input logic full_knob);
    @(negedge clk_in);
    rand_rdy = rdy_knob;
    rand_full = full_knob;
  endtask

  task automatic check_line(input string name, input mem_pkg::line_t got,
                            input mem_pkg::line_t exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input mem_pkg::byte_t got,
                            input mem_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // called at the negedge of the ready cycle
  task automatic check_result(input mem_pkg::xfer_kind_t kind, input mem_pkg::addr_t addr,
                              input mem_pkg::line_t wl);
    case (kind)
      mem_pkg::IF_READ: check_line("if_line", if_line, model_line(addr));
      mem_pkg::D_READ: check_line("d_rline", d_rline, model_line(addr));
      mem_pkg::D_WRITE: check_line("ram line", model_line(addr), wl);
      mem_pkg::IO_READ: check_byte("io_rdata", io_rdata, wl[0]);
      default: begin
        if (io_out_q.size() != 1) begin
          $display("io write produced %0d output bytes instead of one", io_out_q.size());
          errors++;
        end else begin
          check_byte("io output byte", io_out_q.pop_front(), wl[0]);
        end
      end
    endcase
  endtask

  task automatic drive_req(input mem_pkg::xfer_kind_t kind, input mem_pkg::addr_t addr,
                           input mem_pkg::line_t wl);
    case (kind)
      mem_pkg::IF_READ: begin
        if_valid <= 1'b1;
        if_addr <= addr;
      end
      mem_pkg::D_READ, mem_pkg::D_WRITE: begin
        d_valid <= 1'b1;
        d_wr <= (kind == mem_pkg::D_WRITE);
        d_addr <= addr;
        d_wline <= wl;
      end
      default: begin
        io_valid <= 1'b1;
        io_wr <= (kind == mem_pkg::IO_WRITE);
        io_wdata <= wl[0];
        io_in_byte <= wl[0];
      end
    endcase
  endtask

  task automatic run_xfer(input mem_pkg::xfer_kind_t kind, input mem_pkg::addr_t addr,
                          input mem_pkg::line_t wl);
    logic seen;
    @(posedge clk_in);
    drive_req(kind, addr, wl);
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_in);
      seen = if_ready | d_ready | io_ready;
    end
    check_bit("if_ready", if_ready, kind == mem_pkg::IF_READ);
    check_bit("d_ready", d_ready, kind == mem_pkg::D_READ || kind == mem_pkg::D_WRITE);
    check_bit("io_ready", io_ready, kind == mem_pkg::IO_READ || kind == mem_pkg::IO_WRITE);
    check_result(kind, addr, wl);
    @(posedge clk_in);
    if_valid <= 1'b0;
    d_valid <= 1'b0;
    io_valid <= 1'b0;
  endtask

  // all three ports request together and finish io first then data then fetch
  task automatic all_ports(input int rounds);
    mem_pkg::addr_t a_if;
    mem_pkg::addr_t a_d;
    mem_pkg::line_t wl_d;
    mem_pkg::line_t wl_io;
    mem_pkg::xfer_kind_t k_d;
    mem_pkg::xfer_kind_t k_io;
    logic io_done;
    logic d_done;
    logic if_done;
    int n;
    int r;
    for (r = 0; r < rounds; r++) begin
      a_if = rand_addr();
      a_d = rand_addr();
      wl_d = rand_line();
      wl_io = rand_line();
      k_d = ({$random(seed)} % 2 == 1) ? mem_pkg::D_WRITE : mem_pkg::D_READ;
      k_io = ({$random(seed)} % 2 == 1) ? mem_pkg::IO_WRITE : mem_pkg::IO_READ;
      @(posedge clk_in);
      drive_req(mem_pkg::IF_READ, a_if, wl_d);
      drive_req(k_d, a_d, wl_d);
      drive_req(k_io, mem_pkg::IO_BASE, wl_io);
      io_done = 1'b0;
      d_done = 1'b0;
      if_done = 1'b0;
      n = 0;
      while (n < 3) begin
        @(negedge clk_in);
        if (io_ready) begin
          check_byte("io ready order", mem_pkg::byte_t'(n), 8'h00);
          check_result(k_io, mem_pkg::IO_BASE, wl_io);
          io_done = 1'b1;
          n++;
        end
        if (d_ready) begin
          check_byte("d ready order", mem_pkg::byte_t'(n), 8'h01);
          check_result(k_d, a_d, wl_d);
          d_done = 1'b1;
          n++;
        end
        if (if_ready) begin
          check_byte("if ready order", mem_pkg::byte_t'(n), 8'h02);
          check_result(mem_pkg::IF_READ, a_if, wl_d);
          if_done = 1'b1;
          n++;
        end
        @(posedge clk_in);
        if (io_done) io_valid <= 1'b0;
        if (d_done) d_valid <= 1'b0;
        if (if_done) if_valid <= 1'b0;
      end
      repeat (4) begin
        @(negedge clk_in);
        if (if_ready || d_ready || io_ready) begin
          $display("a request completed more than once in round %0d", r);
          errors++;
        end
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == test_errs) ? "ok" : "errors", errors - test_errs);
    test_errs = errors;
  endtask

  initial begin
    int i;
    mem_pkg::addr_t a;
    mem_pkg::line_t wl;
    mem_pkg::xfer_kind_t k;
    seed = 75929;
    knob_seed = 75929;
    errors = 0;
    checks = 0;
    cycles = 0;
    test_errs = 0;
    rand_rdy = 1'b0;
    rand_full = 1'b0;
    uart_busy = 1'b0;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    if_valid = 1'b0;
    if_addr = '0;
    d_valid = 1'b0;
    d_wr = 1'b0;
    d_addr = '0;
    d_wline = '0;
    io_valid = 1'b0;
    io_wr = 1'b0;
    io_wdata = '0;
    is_io_buffer_full = 1'b0;
    mem_din = '0;
    io_in_byte = '0;
    for (i = 0; i < RAM_BYTES; i++) begin
      ram[i] = mem_pkg::byte_t'($random(seed));
    end
    repeat (3) @(posedge clk_in);
    rst_in <= 1'b0;

    @(negedge clk_in);
    check_bit("if_ready", if_ready, 1'b0);
    check_bit("d_ready", d_ready, 1'b0);
    check_bit("io_ready", io_ready, 1'b0);
    check_bit("mem_wr", mem_wr, 1'b0);
    end_test(1, "reset");

    for (i = 0; i < N_TRANS; i++) begin
      run_xfer(mem_pkg::IF_READ, rand_addr(), '0);
    end
    end_test(2, "fetch reads");

    for (i = 0; i < N_TRANS / 2; i++) begin
      a = rand_addr();
      wl = rand_line();
      run_xfer(mem_pkg::D_WRITE, a, wl);
      run_xfer(mem_pkg::D_READ, a, wl);
    end
    end_test(3, "data write/read");

    set_knobs(1'b0, 1'b1);
    for (i = 0; i < N_TRANS; i++) begin
      k = ({$random(seed)} % 2 == 1) ? mem_pkg::IO_WRITE : mem_pkg::IO_READ;
      run_xfer(k, mem_pkg::IO_BASE, rand_line());
    end
    set_knobs(1'b0, 1'b0);
    if (io_out_q.size() != 0) begin
      $display("io output queue holds %0d unexpected bytes", io_out_q.size());
      errors++;
    end
    end_test(4, "io traffic");

    all_ports(N_TRANS / 3);
    end_test(5, "priority");

    // mixed traffic with pauses
    set_knobs(1'b1, 1'b1);
    for (i = 0; i < N_TRANS; i++) begin
      k = rand_kind();
      a = (k == mem_pkg::IO_READ || k == mem_pkg::IO_WRITE) ? mem_pkg::IO_BASE : rand_addr();
      run_xfer(k, a, rand_line());
    end
    set_knobs(1'b0, 1'b0);
    end_test(6, "pauses");

    $display("tests %0d checks %0d errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* bench/mem_ctrl_chk.sv */
`timescale 1ns/1ns

module mem_ctrl_chk (
  input logic           clk_in,
  input logic           rst_in,
  input logic           rdy_in,
  input logic           mem_wr,
  input mem_pkg::addr_t mem_a,
  input logic           if_ready,
  input logic           d_ready,
  input logic           io_ready,
  input logic           is_io_buffer_full
);

  wr_while_paused: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |-> !mem_wr)
    else $error("mem_wr high while rdy_in low");

  if_ready_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    if_ready |=> !if_ready)
    else $error("if_ready longer than one cycle");

  d_ready_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    d_ready |=> !d_ready)
    else $error("d_ready longer than one cycle");

  io_ready_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    io_ready |=> !io_ready)
    else $error("io_ready longer than one cycle");

  one_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    $onehot0({if_ready, d_ready, io_ready}))
    else $error("more than one ready at once");

  // no byte reaches the uart while its buffer is full
  io_wr_room: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_wr && mem_a == mem_pkg::IO_BASE) |-> !is_io_buffer_full)
    else $error("io write landed while the buffer was full");

endmodule

bind mem_ctrl mem_ctrl_chk u_chk (
  .clk_in            (clk_in),
  .rst_in            (rst_in),
  .rdy_in            (rdy_in),
  .mem_wr            (mem_wr),
  .mem_a             (mem_a),
  .if_ready          (if_ready),
  .d_ready           (d_ready),
  .io_ready          (io_ready),
  .is_io_buffer_full (is_io_buffer_full)
);

/* design/mem_ctrl.sv */
`timescale 1ns/1ns

module mem_ctrl (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,

  // ram bus
  input  mem_pkg::byte_t mem_din,
  output mem_pkg::byte_t mem_dout,
  output mem_pkg::addr_t mem_a,
  output logic           mem_wr,

  // instruction fetch
  input  logic           if_valid,
  input  mem_pkg::addr_t if_addr,
  output logic           if_ready,
  output mem_pkg::line_t if_line,

  // data
  input  logic           d_valid,
  input  logic           d_wr,
  input  mem_pkg::addr_t d_addr,
  input  mem_pkg::line_t d_wline,
  output logic           d_ready,
  output mem_pkg::line_t d_rline,

  // io, always at IO_BASE
  input  logic           io_valid,
  input  logic           io_wr,
  input  mem_pkg::byte_t io_wdata,
  output logic           io_ready,
  output mem_pkg::byte_t io_rdata,
  input  logic           is_io_buffer_full
);

  xfer_if xf ();

  xfer_fsm u_fsm (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .rdy_in            (rdy_in),
    .if_valid          (if_valid),
    .if_addr           (if_addr),
    .if_ready          (if_ready),
    .d_valid           (d_valid),
    .d_wr              (d_wr),
    .d_addr            (d_addr),
    .d_wline           (d_wline),
    .d_ready           (d_ready),
    .io_valid          (io_valid),
    .io_wr             (io_wr),
    .io_wdata          (io_wdata),
    .io_ready          (io_ready),
    .is_io_buffer_full (is_io_buffer_full),
    .xf                (xf)
  );

  byte_counter u_counter (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .rdy_in (rdy_in),
    .xf     (xf)
  );

  ram_port u_ram (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .xf       (xf),
    .mem_a    (mem_a),
    .mem_dout (mem_dout),
    .mem_wr   (mem_wr)
  );

  line_collect u_collect (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .xf       (xf),
    .mem_din  (mem_din),
    .if_line  (if_line),
    .d_rline  (d_rline),
    .io_rdata (io_rdata)
  );

endmodule

/* design/line_collect.sv */
`timescale 1ns/1ns

module line_collect (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,
  xfer_if.collect        xf,
  input  mem_pkg::byte_t mem_din,
  output mem_pkg::line_t if_line,
  output mem_pkg::line_t d_rline,
  output mem_pkg::byte_t io_rdata
);

  logic is_rd;
  logic a_rd;
  logic d_rd;
  mem_pkg::idx_t a_idx;
  mem_pkg::idx_t d_idx;

  assign is_rd = (xf.kind == mem_pkg::IF_READ) || (xf.kind == mem_pkg::D_READ) ||
                 (xf.kind == mem_pkg::IO_READ);

  // mirrors the index of the address now on mem_a
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      a_rd <= 1'b0;
    end else if (rdy_in) begin
      a_rd <= xf.step && is_rd;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && xf.step) begin
      a_idx <= xf.idx;
    end
  end

  // the RAM answers every cycle, paused or not, so this stage runs freely
  // and stays matched to the byte on mem_din
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      d_rd <= 1'b0;
    end else begin
      d_rd <= a_rd;
    end
  end

  always_ff @(posedge clk_in) begin
    d_idx <= a_idx;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      if_line <= '0;
      d_rline <= '0;
      io_rdata <= '0;
    end else if (d_rd) begin
      case (xf.kind)
        mem_pkg::IF_READ: if_line[d_idx] <= mem_din;
        mem_pkg::D_READ:  d_rline[d_idx] <= mem_din;
        mem_pkg::IO_READ: io_rdata <= mem_din;
        default: ;
      endcase
    end
  end

endmodule

/* design/ram_port.sv */
`timescale 1ns/1ns

module ram_port (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,
  xfer_if.bus            xf,
  output mem_pkg::addr_t mem_a,
  output mem_pkg::byte_t mem_dout,
  output logic           mem_wr
);

  logic is_wr;
  logic wr_q;

  assign is_wr = (xf.kind == mem_pkg::D_WRITE) || (xf.kind == mem_pkg::IO_WRITE);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      mem_a <= '0;
      mem_dout <= '0;
      wr_q <= 1'b0;
    end else if (rdy_in) begin
      wr_q <= xf.step && is_wr;
      if (xf.step) begin
        mem_a <= xf.base + mem_pkg::addr_t'(xf.idx);
        if (is_wr) begin
          mem_dout <= xf.wline[xf.idx];
        end
      end
    end
  end

  // a write caught by a pause stays pending and lands once rdy_in returns
  assign mem_wr = wr_q && rdy_in;

endmodule

/* design/byte_counter.sv */
`timescale 1ns/1ns

module byte_counter (
  input  logic clk_in,
  input  logic rst_in,
  input  logic rdy_in,
  xfer_if.counter xf
);

  mem_pkg::idx_t idx_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      idx_q <= '0;
    end else if (rdy_in) begin
      if (xf.start) begin
        idx_q <= '0;
      end else if (xf.step) begin
        // wraps back to zero after the last byte
        idx_q <= idx_q + mem_pkg::idx_t'(1);
      end
    end
  end

  assign xf.idx = idx_q;

  assign xf.last = (idx_q == mem_pkg::LAST_IDX);

endmodule

/* design/xfer_fsm.sv */
`timescale 1ns/1ns

module xfer_fsm (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,

  input  logic           if_valid,
  input  mem_pkg::addr_t if_addr,
  output logic           if_ready,

  input  logic           d_valid,
  input  logic           d_wr,
  input  mem_pkg::addr_t d_addr,
  input  mem_pkg::line_t d_wline,
  output logic           d_ready,

  input  logic           io_valid,
  input  logic           io_wr,
  input  mem_pkg::byte_t io_wdata,
  output logic           io_ready,

  input  logic           is_io_buffer_full,
  xfer_if.fsm            xf
);

  // tail covers the last address on the bus, cap the last read byte coming back
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_XFER,
    ST_HOLD,
    ST_TAIL,
    ST_CAP,
    ST_DONE
  } state_t;

  state_t state_q;
  mem_pkg::xfer_kind_t kind_q;
  mem_pkg::xfer_kind_t kind_sel;
  mem_pkg::addr_t base_q;
  mem_pkg::line_t wline_q;
  logic is_read;
  logic done;

  // fixed priority: io, then data, then fetch
  always_comb begin
    if (io_valid) begin
      kind_sel = io_wr ? mem_pkg::IO_WRITE : mem_pkg::IO_READ;
    end else if (d_valid) begin
      kind_sel = d_wr ? mem_pkg::D_WRITE : mem_pkg::D_READ;
    end else if (if_valid) begin
      kind_sel = mem_pkg::IF_READ;
    end else begin
      kind_sel = mem_pkg::NONE;
    end
  end

  assign is_read = (kind_q == mem_pkg::IF_READ) || (kind_q == mem_pkg::D_READ) ||
                   (kind_q == mem_pkg::IO_READ);

  assign xf.start = (state_q == ST_IDLE) && (kind_sel != mem_pkg::NONE);

  // an io write only goes out while the uart buffer has room
  assign xf.step = (state_q == ST_XFER) || ((state_q == ST_HOLD) && !is_io_buffer_full);

  assign xf.kind = kind_q;
  assign xf.base = base_q;
  assign xf.wline = wline_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= ST_IDLE;
      kind_q <= mem_pkg::NONE;
    end else if (rdy_in) begin
      case (state_q)
        ST_IDLE: begin
          if (xf.start) begin
            kind_q <= kind_sel;
            state_q <= (kind_sel == mem_pkg::IO_WRITE) ? ST_HOLD : ST_XFER;
          end
        end
        ST_XFER: begin
          // io reads are a single byte
          if (xf.last || (kind_q == mem_pkg::IO_READ)) begin
            state_q <= ST_TAIL;
          end
        end
        ST_HOLD: begin
          if (!is_io_buffer_full) begin
            state_q <= ST_TAIL;
          end
        end
        ST_TAIL: begin
          state_q <= is_read ? ST_CAP : ST_DONE;
        end
        ST_CAP: begin
          state_q <= ST_DONE;
        end
        ST_DONE: begin
          state_q <= ST_IDLE;
          kind_q <= mem_pkg::NONE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && xf.start) begin
      base_q <= io_valid ? mem_pkg::IO_BASE : (d_valid ? d_addr : if_addr);
      wline_q <= io_valid ? mem_pkg::line_t'(io_wdata) : d_wline;
    end
  end

  // one cycle only, even across a pause
  assign done = (state_q == ST_DONE) && rdy_in;

  assign if_ready = done && (kind_q == mem_pkg::IF_READ);
  assign d_ready = done && ((kind_q == mem_pkg::D_READ) || (kind_q == mem_pkg::D_WRITE));
  assign io_ready = done && ((kind_q == mem_pkg::IO_READ) || (kind_q == mem_pkg::IO_WRITE));

endmodule

/* design/xfer_if.sv */
`timescale 1ns/1ns

interface xfer_if;

  mem_pkg::xfer_kind_t kind;
  mem_pkg::addr_t base;
  mem_pkg::line_t wline;

  // start clears the byte index, step walks one byte
  logic start;
  logic step;

  mem_pkg::idx_t idx;
  logic last;

  modport fsm (
    output kind,
    output base,
    output wline,
    output start,
    output step,
    input  idx,
    input  last
  );

  modport counter (
    input  start,
    input  step,
    output idx,
    output last
  );

  modport bus (
    input kind,
    input base,
    input wline,
    input idx,
    input step
  );

  modport collect (
    input kind,
    input idx,
    input step
  );

endinterface

/* design/mem_pkg.sv */
package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int BYTE_W = 8;
  localparam int LINE_BYTES = 8;
  localparam int IDX_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // byte 0 in the low bits, taken from the lowest address
  typedef byte_t [LINE_BYTES-1:0] line_t;

  typedef logic [IDX_W-1:0] idx_t;

  // uart data port
  localparam addr_t IO_BASE = 32'h0003_0000;

  localparam idx_t LAST_IDX = idx_t'(LINE_BYTES - 1);

  typedef enum logic [2:0] {
    NONE,
    IF_READ,
    D_READ,
    D_WRITE,
    IO_READ,
    IO_WRITE
  } xfer_kind_t;

endpackage
